//--- verilog/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] word_t;   // requester data
  typedef logic [63:0] dword_t;  // bus data
  typedef logic [3:0]  wstrb_t;  // one bit per byte of a word
  typedef logic [7:0]  bus_strb_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_resp_t;

  // arbiter states
  typedef enum logic [2:0] {
    BUS_IDLE   = 3'd0,
    BUS_IF_AR  = 3'd1,  // fetch address phase
    BUS_IF_R   = 3'd2,
    BUS_LD_AR  = 3'd3,
    BUS_LD_R   = 3'd4,
    BUS_ST_REQ = 3'd5,  // aw and w together
    BUS_ST_B   = 3'd6,
    BUS_TIMER  = 3'd7   // local mtime read, no bus traffic
  } bus_state_t;

  // machine time, low and high word
  localparam addr_t MTIME_LO_ADDR = 32'h0200_BFF8;
  localparam addr_t MTIME_HI_ADDR = 32'h0200_BFFC;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // transfer size codes
  localparam axi_size_t SIZE_BYTE = 3'd0;
  localparam axi_size_t SIZE_HALF = 3'd1;
  localparam axi_size_t SIZE_WORD = 3'd2;

endpackage

`default_nettype wire

//--- verilog/cpu_bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_arbiter
  import cpu_bus_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  // requests
  input  wire   ifu_arvalid_i,
  input  wire   lsu_arvalid_i,
  input  addr_t lsu_araddr_i,
  input  wire   lsu_awvalid_i,

  // axi handshake inputs
  input  wire   m_arready_i,
  input  wire   m_rvalid_i,
  input  wire   m_awready_i,
  input  wire   m_wready_i,
  input  wire   m_bvalid_i,

  input  wire   timer_rvalid_i,

  output logic  grant_lsu_o,
  output logic  m_arvalid_o,
  output logic  m_rready_o,
  output logic  m_awvalid_o,
  output logic  m_wvalid_o,
  output logic  m_bready_o,
  output logic  timer_rd_en_o,
  output logic  ifu_rvalid_o,
  output logic  lsu_rvalid_o,
  output logic  lsu_wready_o,
  output logic  use_timer_o
);

  bus_state_t state, state_nxt;
  logic       aw_done;  // aw handshake seen for this store
  logic       w_done;
  logic       is_timer_ld;
  logic       aw_fire;
  logic       w_fire;

  assign is_timer_ld = (lsu_araddr_i == MTIME_LO_ADDR) || (lsu_araddr_i == MTIME_HI_ADDR);

  assign aw_fire = m_awvalid_o && m_awready_i;
  assign w_fire  = m_wvalid_o && m_wready_i;

  always_comb begin
    state_nxt = state;
    case (state)
      BUS_IDLE: begin
        // lsu before ifu, load before store
        if (lsu_arvalid_i) begin
          state_nxt = is_timer_ld ? BUS_TIMER : BUS_LD_AR;
        end else if (lsu_awvalid_i) begin
          state_nxt = BUS_ST_REQ;
        end else if (ifu_arvalid_i) begin
          state_nxt = BUS_IF_AR;
        end
      end
      BUS_IF_AR: if (m_arready_i) state_nxt = BUS_IF_R;
      BUS_IF_R:  if (m_rvalid_i) state_nxt = BUS_IDLE;
      BUS_LD_AR: if (m_arready_i) state_nxt = BUS_LD_R;
      BUS_LD_R:  if (m_rvalid_i) state_nxt = BUS_IDLE;
      BUS_ST_REQ: begin
        if ((aw_done || aw_fire) && (w_done || w_fire)) begin
          state_nxt = BUS_ST_B;
        end
      end
      BUS_ST_B:  if (m_bvalid_i) state_nxt = BUS_IDLE;
      BUS_TIMER: if (timer_rvalid_i) state_nxt = BUS_IDLE;
      default:   state_nxt = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BUS_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // aw and w may complete in different cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (state == BUS_IDLE) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (aw_fire) aw_done <= 1'b1;
      if (w_fire) w_done <= 1'b1;
    end
  end

  assign m_arvalid_o = (state == BUS_IF_AR) || (state == BUS_LD_AR);
  assign m_rready_o  = (state == BUS_IF_R) || (state == BUS_LD_R);
  assign m_awvalid_o = (state == BUS_ST_REQ) && !aw_done;
  assign m_wvalid_o  = (state == BUS_ST_REQ) && !w_done;
  assign m_bready_o  = (state == BUS_ST_B);

  // timer samples on the same edge that enters BUS_TIMER
  assign timer_rd_en_o = (state == BUS_IDLE) && lsu_arvalid_i && is_timer_ld;
  assign use_timer_o   = (state == BUS_TIMER);

  assign grant_lsu_o = (state == BUS_LD_AR) || (state == BUS_LD_R) ||
                       (state == BUS_ST_REQ) || (state == BUS_ST_B) ||
                       (state == BUS_TIMER);

  // done pulses
  assign ifu_rvalid_o = (state == BUS_IF_R) && m_rvalid_i;
  assign lsu_rvalid_o = ((state == BUS_LD_R) && m_rvalid_i) ||
                        ((state == BUS_TIMER) && timer_rvalid_i);
  assign lsu_wready_o = (state == BUS_ST_B) && m_bvalid_i;

endmodule

`default_nettype wire

//--- verilog/axi_lane_steer.sv
`timescale 1ns/10ps
`default_nettype none

module axi_lane_steer
  import cpu_bus_pkg::*;
(
  // read side
  input  addr_t     rd_addr_i,
  input  wstrb_t    rd_strb_i,
  input  wire       rd_is_fetch_i,
  input  dword_t    m_rdata_i,

  // write side
  input  addr_t     wr_addr_i,
  input  word_t     wr_data_i,
  input  wstrb_t    wr_strb_i,

  output axi_size_t arsize_o,
  output axi_size_t awsize_o,
  output word_t     rdata_o,
  output dword_t    m_wdata_o,
  output bus_strb_t m_wstrb_o
);

  word_t  wdata_sh;
  wstrb_t wstrb_sh;

  // size from number of enabled bytes
  function automatic axi_size_t strb_size(input wstrb_t strb);
    axi_size_t sz;
    case (strb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: sz = SIZE_BYTE;
      4'b0011, 4'b0110, 4'b1100:          sz = SIZE_HALF;
      default:                            sz = SIZE_WORD;
    endcase
    return sz;
  endfunction

  assign arsize_o = rd_is_fetch_i ? SIZE_WORD : strb_size(rd_strb_i);
  assign awsize_o = strb_size(wr_strb_i);

  // move data to its byte offset inside the word
  assign wdata_sh = wr_data_i << {wr_addr_i[1:0], 3'b000};
  assign wstrb_sh = wr_strb_i << wr_addr_i[1:0];

  assign m_wdata_o = {wdata_sh, wdata_sh};  // same word in both halves

  always_comb begin
    if (wr_addr_i[2]) begin
      m_wstrb_o = {wstrb_sh, 4'b0000};
    end else begin
      m_wstrb_o = {4'b0000, wstrb_sh};
    end
  end

  // upper or lower half, not shifted
  assign rdata_o = rd_addr_i[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];

endmodule

`default_nettype wire

//--- verilog/core_timer.sv
`timescale 1ns/10ps
`default_nettype none

module core_timer
  import cpu_bus_pkg::*;
(
  input  wire   clk,
  input  wire   rst,
  input  wire   rd_en_i,
  input  wire   rd_hi_i,   // 1 selects mtime[63:32]
  output word_t rdata_o,
  output logic  rvalid_o
);

  dword_t mtime;
  word_t  rdata_q;

  // free running, one tick per clock
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rdata_q <= rd_hi_i ? mtime[63:32] : mtime[31:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_en_i;  // one cycle after the read strobe
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- verilog/cpu_bus.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_bus
  import cpu_bus_pkg::*;
(
  input  wire       clk,
  input  wire       rst,

  // ifu read
  input  wire       ifu_arvalid_i,
  input  addr_t     ifu_araddr_i,
  output word_t     ifu_rdata_o,
  output logic      ifu_rvalid_o,

  // lsu load
  input  wire       lsu_arvalid_i,
  input  addr_t     lsu_araddr_i,
  input  wstrb_t    lsu_rstrb_i,
  output word_t     lsu_rdata_o,
  output logic      lsu_rvalid_o,

  // lsu store
  input  wire       lsu_awvalid_i,
  input  addr_t     lsu_awaddr_i,
  input  word_t     lsu_wdata_i,
  input  wstrb_t    lsu_wstrb_i,
  output logic      lsu_wready_o,

  // axi read address
  output addr_t     m_araddr_o,
  output axi_size_t m_arsize_o,
  output logic      m_arvalid_o,
  input  wire       m_arready_i,

  // axi read data
  input  dword_t    m_rdata_i,
  input  axi_resp_t m_rresp_i,
  input  wire       m_rvalid_i,
  output logic      m_rready_o,

  // axi write address
  output addr_t     m_awaddr_o,
  output axi_size_t m_awsize_o,
  output logic      m_awvalid_o,
  input  wire       m_awready_i,

  // axi write data
  output dword_t    m_wdata_o,
  output bus_strb_t m_wstrb_o,
  output logic      m_wlast_o,
  output logic      m_wvalid_o,
  input  wire       m_wready_i,

  // axi write response
  input  axi_resp_t m_bresp_i,
  input  wire       m_bvalid_i,
  output logic      m_bready_o
);

  logic  grant_lsu;
  logic  use_timer;
  logic  timer_rd_en;
  logic  timer_rvalid;
  word_t timer_rdata;
  word_t bus_rdata;

  cpu_bus_arbiter u_arb (
    .clk            (clk),
    .rst            (rst),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_awvalid_i  (lsu_awvalid_i),
    .m_arready_i    (m_arready_i),
    .m_rvalid_i     (m_rvalid_i),
    .m_awready_i    (m_awready_i),
    .m_wready_i     (m_wready_i),
    .m_bvalid_i     (m_bvalid_i),
    .timer_rvalid_i (timer_rvalid),
    .grant_lsu_o    (grant_lsu),
    .m_arvalid_o    (m_arvalid_o),
    .m_rready_o     (m_rready_o),
    .m_awvalid_o    (m_awvalid_o),
    .m_wvalid_o     (m_wvalid_o),
    .m_bready_o     (m_bready_o),
    .timer_rd_en_o  (timer_rd_en),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_wready_o   (lsu_wready_o),
    .use_timer_o    (use_timer)
  );

  assign m_araddr_o = grant_lsu ? lsu_araddr_i : ifu_araddr_i;
  assign m_awaddr_o = lsu_awaddr_i;
  assign m_wlast_o  = m_wvalid_o;  // single beat

  axi_lane_steer u_steer (
    .rd_addr_i     (m_araddr_o),
    .rd_strb_i     (lsu_rstrb_i),
    .rd_is_fetch_i (!grant_lsu),
    .m_rdata_i     (m_rdata_i),
    .wr_addr_i     (lsu_awaddr_i),
    .wr_data_i     (lsu_wdata_i),
    .wr_strb_i     (lsu_wstrb_i),
    .arsize_o      (m_arsize_o),
    .awsize_o      (m_awsize_o),
    .rdata_o       (bus_rdata),
    .m_wdata_o     (m_wdata_o),
    .m_wstrb_o     (m_wstrb_o)
  );

  // hi word lives at bit 2 set
  core_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_en_i  (timer_rd_en),
    .rd_hi_i  (lsu_araddr_i[2]),
    .rdata_o  (timer_rdata),
    .rvalid_o (timer_rvalid)
  );

  assign ifu_rdata_o = bus_rdata;
  assign lsu_rdata_o = use_timer ? timer_rdata : bus_rdata;

endmodule

`default_nettype wire

//--- test/cpu_bus_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_assertions
  import cpu_bus_pkg::*;
(
  input wire       clk,
  input wire       rst,
  input wire       m_arvalid_o,
  input wire       m_arready_i,
  input addr_t     m_araddr_o,
  input wire       m_awvalid_o,
  input wire       m_awready_i,
  input addr_t     m_awaddr_o,
  input wire       m_wvalid_o,
  input wire       m_wready_i,
  input wire       m_wlast_o,
  input dword_t    m_wdata_o,
  input bus_strb_t m_wstrb_o,
  input wire       m_rvalid_i,
  input wire       m_rready_o,
  input axi_resp_t m_rresp_i,
  input wire       m_bvalid_i,
  input wire       m_bready_o,
  input axi_resp_t m_bresp_i
);

  ar_held: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else $error("arvalid dropped or araddr moved before arready");

  aw_held: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
    else $error("awvalid dropped or awaddr moved before awready");

  // payload too, not just the valid
  w_held: assert property (@(posedge clk) disable iff (rst)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o))
    else $error("wvalid dropped or write data moved before wready");

  wlast_single: assert property (@(posedge clk) disable iff (rst)
    m_wlast_o == m_wvalid_o)
    else $error("wlast differs from wvalid");

  r_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i && m_rready_o |-> m_rresp_i == RESP_OKAY)
    else $error("read response not OKAY");

  b_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i && m_bready_o |-> m_bresp_i == RESP_OKAY)
    else $error("write response not OKAY");

  one_addr: assert property (@(posedge clk) disable iff (rst)
    !(m_arvalid_o && m_awvalid_o))
    else $error("arvalid and awvalid high together");

endmodule

bind cpu_bus cpu_bus_assertions u_axi_chk (
  .clk (clk), .rst (rst),
  .m_arvalid_o (m_arvalid_o), .m_arready_i (m_arready_i), .m_araddr_o (m_araddr_o),
  .m_awvalid_o (m_awvalid_o), .m_awready_i (m_awready_i), .m_awaddr_o (m_awaddr_o),
  .m_wvalid_o (m_wvalid_o), .m_wready_i (m_wready_i), .m_wlast_o (m_wlast_o),
  .m_wdata_o (m_wdata_o), .m_wstrb_o (m_wstrb_o),
  .m_rvalid_i (m_rvalid_i), .m_rready_o (m_rready_o), .m_rresp_i (m_rresp_i),
  .m_bvalid_i (m_bvalid_i), .m_bready_o (m_bready_o), .m_bresp_i (m_bresp_i)
);

`default_nettype wire

//--- test/cpu_bus_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_tb;
  import cpu_bus_pkg::*;

  localparam logic [31:0] SEED = 32'hc831_d726;
  localparam int TIMEOUT = 200;  // cycles per wait

  typedef enum int {PORT_IFU, PORT_LOAD, PORT_STORE, PORT_BOTH} port_e;

  logic clk;
  logic rst;
  logic ifu_arvalid, lsu_arvalid, lsu_awvalid;
  addr_t ifu_araddr, lsu_araddr, lsu_awaddr;
  wstrb_t lsu_rstrb, lsu_wstrb;
  word_t lsu_wdata, ifu_rdata, lsu_rdata;
  logic ifu_rvalid, lsu_rvalid, lsu_wready;
  addr_t m_araddr, m_awaddr;
  axi_size_t m_arsize, m_awsize;
  logic m_arvalid, m_rready, m_awvalid, m_wvalid, m_wlast, m_bready;
  logic m_arready = 1'b0;
  logic m_rvalid = 1'b0;
  logic m_awready = 1'b0;
  logic m_wready = 1'b0;
  logic m_bvalid = 1'b0;
  dword_t m_rdata = '0;
  dword_t m_wdata;
  bus_strb_t m_wstrb;
  axi_resp_t m_rresp = RESP_OKAY;  // slave never errors
  axi_resp_t m_bresp = RESP_OKAY;

  // slave memory, 2 KiB window, and the expected copy
  dword_t slave_mem [256];
  word_t  model_mem [512];
  int     stall_tab [256];
  int     stall_idx = 0;

  // slave state
  int ar_wait = 0, r_wait = 0, aw_wait = 0, w_wait = 0, b_wait = 0;
  logic ar_pending = 1'b0, aw_have = 1'b0, w_have = 1'b0, b_pending = 1'b0;
  addr_t ar_addr_q, aw_addr_q;
  dword_t w_data_q;
  bus_strb_t w_strb_q;

  addr_t     ar_log_addr [$];
  axi_size_t ar_log_size [$];
  axi_size_t aw_log_size [$];

  string  row_name [$];
  port_e  row_port [$];
  addr_t  row_addr [$];
  word_t  row_data [$];
  wstrb_t row_strb [$];
  word_t  row_exp [$];
  word_t  row_exp2 [$];  // ifu word for PORT_BOTH

  cpu_bus dut0 (
    .clk (clk), .rst (rst),
    .ifu_arvalid_i (ifu_arvalid), .ifu_araddr_i (ifu_araddr),
    .ifu_rdata_o (ifu_rdata), .ifu_rvalid_o (ifu_rvalid),
    .lsu_arvalid_i (lsu_arvalid), .lsu_araddr_i (lsu_araddr), .lsu_rstrb_i (lsu_rstrb),
    .lsu_rdata_o (lsu_rdata), .lsu_rvalid_o (lsu_rvalid),
    .lsu_awvalid_i (lsu_awvalid), .lsu_awaddr_i (lsu_awaddr),
    .lsu_wdata_i (lsu_wdata), .lsu_wstrb_i (lsu_wstrb), .lsu_wready_o (lsu_wready),
    .m_araddr_o (m_araddr), .m_arsize_o (m_arsize),
    .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
    .m_rdata_i (m_rdata), .m_rresp_i (m_rresp), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready),
    .m_awaddr_o (m_awaddr), .m_awsize_o (m_awsize),
    .m_awvalid_o (m_awvalid), .m_awready_i (m_awready),
    .m_wdata_o (m_wdata), .m_wstrb_o (m_wstrb), .m_wlast_o (m_wlast),
    .m_wvalid_o (m_wvalid), .m_wready_i (m_wready),
    .m_bresp_i (m_bresp), .m_bvalid_i (m_bvalid), .m_bready_o (m_bready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h1357_2468;
  endfunction

  function automatic int next_stall();
    stall_idx = (stall_idx + 1) % 256;
    return stall_tab[stall_idx];
  endfunction

  // byte k of the word takes data byte k - offset
  function automatic void model_store(input addr_t a, input word_t d, input wstrb_t s);
    int off;
    off = int'(a[1:0]);
    for (int k = 0; k < 4; k++) begin
      if (k >= off) begin
        if (s[k - off]) model_mem[a[10:2]][8*k +: 8] = d[8*(k - off) +: 8];
      end
    end
  endfunction

  function automatic axi_size_t size_of(input wstrb_t s);
    if ($countones(s) > 2) return 3'd2;
    return ($countones(s) == 2) ? 3'd1 : 3'd0;
  endfunction

  function automatic logic done_of(input int which);
    case (which)
      0: return ifu_rvalid;
      1: return lsu_rvalid;
      default: return lsu_wready;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("error %s expected %h actual %h", name, exp, act);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped on a protocol problem");
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    assert (act == exp) else report_mismatch(name, exp, act);
  endtask

  // returns at the posedge where the done pulse is seen
  task automatic wait_done(input string what, input int which, output int edges);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      if (edges > TIMEOUT) report_problem({"timeout waiting for done pulse in ", what});
    end while (!done_of(which));
  endtask

  task automatic add_row(input string name, input port_e port, input addr_t a,
                         input word_t d, input wstrb_t s);
    word_t e1, e2;
    e1 = '0;
    e2 = '0;
    case (port)
      PORT_STORE: model_store(a, d, s);
      PORT_BOTH: begin
        e1 = model_mem[a[10:2]];
        e2 = model_mem[d[10:2]];
      end
      default: e1 = model_mem[a[10:2]];
    endcase
    row_name.push_back(name);
    row_port.push_back(port);
    row_addr.push_back(a);
    row_data.push_back(d);
    row_strb.push_back(s);
    row_exp.push_back(e1);
    row_exp2.push_back(e2);
  endtask

  task automatic build_table();
    addr_t a;
    word_t d;
    add_row("fetch_lo", PORT_IFU, 32'h100, '0, 4'hf);
    add_row("fetch_hi", PORT_IFU, 32'h104, '0, 4'hf);
    add_row("fetch_top", PORT_IFU, 32'h7fc, '0, 4'hf);
    for (int k = 0; k < 4; k++) begin
      add_row($sformatf("sb_off%0d", k), PORT_STORE, 32'h200 + k, 32'ha0 + k, 4'b0001);
      add_row($sformatf("lw_after_sb%0d", k), PORT_LOAD, 32'h200, '0, 4'hf);
    end
    for (int k = 0; k < 3; k++) begin
      add_row($sformatf("sh_off%0d", k), PORT_STORE, 32'h214 + k, 32'hbe00 + k, 4'b0011);
      add_row($sformatf("lh_after_sh%0d", k), PORT_LOAD, 32'h214 + k, '0, 4'b0011);
    end
    add_row("sw", PORT_STORE, 32'h220, 32'hcafe_f00d, 4'hf);
    add_row("lb_after_sw", PORT_LOAD, 32'h223, '0, 4'b0001);
    add_row("both_lo", PORT_BOTH, 32'h220, 32'h104, 4'hf);
    add_row("both_hi", PORT_BOTH, 32'h214, 32'h200, 4'hf);
    for (int n = 0; n < 40; n++) begin
      a = 32'h300 + (($urandom % 64) << 2);
      d = $urandom;
      case ($urandom % 5)
        0: add_row($sformatf("rnd%0d_fetch", n), PORT_IFU, a, d, 4'hf);
        1: add_row($sformatf("rnd%0d_lw", n), PORT_LOAD, a, d, 4'hf);
        2: add_row($sformatf("rnd%0d_sb", n), PORT_STORE, a + ($urandom % 4), d, 4'b0001);
        3: add_row($sformatf("rnd%0d_sh", n), PORT_STORE, a + ($urandom % 3), d, 4'b0011);
        default: add_row($sformatf("rnd%0d_sw", n), PORT_STORE, a, d, 4'hf);
      endcase
    end
  endtask

  // called and returns on a falling edge
  task automatic apply_row(input int i);
    word_t got;
    int edges, n_ar, n_aw;
    n_ar = ar_log_addr.size();
    n_aw = aw_log_size.size();
    case (row_port[i])
      PORT_IFU: begin
        ifu_araddr = row_addr[i];
        ifu_arvalid = 1'b1;
        wait_done(row_name[i], 0, edges);
        got = ifu_rdata;
        @(negedge clk);
        ifu_arvalid = 1'b0;
        check_value(row_name[i], row_exp[i], got);
        check_value({row_name[i], " arsize"}, 32'd2, word_t'(ar_log_size[n_ar]));
      end
      PORT_LOAD: begin
        lsu_araddr = row_addr[i];
        lsu_rstrb = row_strb[i];
        lsu_arvalid = 1'b1;
        wait_done(row_name[i], 1, edges);
        got = lsu_rdata;
        @(negedge clk);
        lsu_arvalid = 1'b0;
        check_value(row_name[i], row_exp[i], got);
        check_value({row_name[i], " arsize"}, word_t'(size_of(row_strb[i])),
                    word_t'(ar_log_size[n_ar]));
      end
      PORT_STORE: begin
        lsu_awaddr = row_addr[i];
        lsu_wdata = row_data[i];
        lsu_wstrb = row_strb[i];
        lsu_awvalid = 1'b1;
        wait_done(row_name[i], 2, edges);
        @(negedge clk);
        lsu_awvalid = 1'b0;
        check_value({row_name[i], " awsize"}, word_t'(size_of(row_strb[i])),
                    word_t'(aw_log_size[n_aw]));
      end
      default: begin
        lsu_araddr = row_addr[i];
        lsu_rstrb = 4'hf;
        lsu_arvalid = 1'b1;
        ifu_araddr = row_data[i];
        ifu_arvalid = 1'b1;
        wait_done(row_name[i], 1, edges);
        got = lsu_rdata;
        @(negedge clk);
        lsu_arvalid = 1'b0;
        check_value(row_name[i], row_exp[i], got);
        check_value({row_name[i], " lsu first"}, row_addr[i], ar_log_addr[n_ar]);
        wait_done(row_name[i], 0, edges);
        got = ifu_rdata;
        @(negedge clk);
        ifu_arvalid = 1'b0;
        check_value({row_name[i], " ifu"}, row_exp2[i], got);
      end
    endcase
  endtask

  task automatic timer_read(input addr_t a, output word_t val, output int edges);
    int n_ar, n_aw;
    n_ar = ar_log_addr.size();
    n_aw = aw_log_size.size();
    lsu_araddr = a;
    lsu_rstrb = 4'hf;
    lsu_arvalid = 1'b1;
    wait_done("timer read", 1, edges);
    val = lsu_rdata;
    @(negedge clk);
    lsu_arvalid = 1'b0;
    assert (ar_log_addr.size() == n_ar && aw_log_size.size() == n_aw)
      else report_problem("timer read caused traffic on the AXI bus");
  endtask

  // handshakes are taken at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (m_arvalid && m_arready) begin
        ar_addr_q = m_araddr;
        ar_pending = 1'b1;
        ar_log_addr.push_back(m_araddr);
        ar_log_size.push_back(m_arsize);
      end
      if (m_awvalid && m_awready) begin
        aw_addr_q = m_awaddr;
        aw_have = 1'b1;
        aw_log_size.push_back(m_awsize);
      end
      if (m_wvalid && m_wready) begin
        w_data_q = m_wdata;
        w_strb_q = m_wstrb;
        w_have = 1'b1;
      end
    end
  end

  // slave outputs change on the falling edge, with 0 to 3 stall cycles
  always @(negedge clk) begin
    if (rst) begin
      m_arready = 1'b0;
      m_rvalid = 1'b0;
      m_awready = 1'b0;
      m_wready = 1'b0;
      m_bvalid = 1'b0;
    end else begin
      if (m_arready) m_arready = 1'b0;
      else if (m_arvalid) begin
        if (ar_wait == 0) begin
          m_arready = 1'b1;
          ar_wait = next_stall();
        end else ar_wait--;
      end
      if (m_rvalid) m_rvalid = 1'b0;  // rready is high in every read data state
      else if (ar_pending) begin
        if (r_wait == 0) begin
          m_rdata = slave_mem[ar_addr_q[10:3]];
          m_rvalid = 1'b1;
          ar_pending = 1'b0;
          r_wait = next_stall();
        end else r_wait--;
      end
      if (m_awready) m_awready = 1'b0;
      else if (m_awvalid) begin
        if (aw_wait == 0) begin
          m_awready = 1'b1;
          aw_wait = next_stall();
        end else aw_wait--;
      end
      if (m_wready) m_wready = 1'b0;
      else if (m_wvalid) begin
        if (w_wait == 0) begin
          m_wready = 1'b1;
          w_wait = next_stall();
        end else w_wait--;
      end
      if (aw_have && w_have) begin
        for (int k = 0; k < 8; k++) begin
          if (w_strb_q[k]) slave_mem[aw_addr_q[10:3]][8*k +: 8] = w_data_q[8*k +: 8];
        end
        aw_have = 1'b0;
        w_have = 1'b0;
        b_pending = 1'b1;
      end
      if (m_bvalid) m_bvalid = 1'b0;
      else if (b_pending) begin
        if (b_wait == 0) begin
          m_bvalid = 1'b1;
          b_pending = 1'b0;
          b_wait = next_stall();
        end else b_wait--;
      end
    end
  end

  initial begin : stimulus
    word_t t0, t1;
    int edges;
    ifu_arvalid = 1'b0;
    ifu_araddr = '0;
    lsu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_rstrb = '0;
    lsu_awvalid = 1'b0;
    lsu_awaddr = '0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    rst = 1'b1;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) begin
      stall_tab[i] = int'($urandom % 4);
      slave_mem[i] = {fill_word(addr_t'(i * 8 + 4)), fill_word(addr_t'(i * 8))};
      model_mem[2 * i] = fill_word(addr_t'(i * 8));
      model_mem[2 * i + 1] = fill_word(addr_t'(i * 8 + 4));
    end
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!m_arvalid && !m_awvalid && !m_wvalid && !m_wlast && !m_rready && !m_bready &&
            !ifu_rvalid && !lsu_rvalid && !lsu_wready)
      else report_problem("bus outputs not idle after reset");
    for (int i = 0; i < row_name.size(); i++) begin
      apply_row(i);
    end
    timer_read(MTIME_LO_ADDR, t0, edges);
    check_value("timer_latency", 32'd2, word_t'(edges));
    timer_read(MTIME_LO_ADDR, t1, edges);
    assert (t1 > t0) else report_problem("machine time did not advance between reads");
    timer_read(MTIME_HI_ADDR, t1, edges);
    check_value("timer_hi", 32'd0, t1);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/cpu_bus_pkg.sv
verilog/cpu_bus_arbiter.sv
verilog/axi_lane_steer.sv
verilog/core_timer.sv
verilog/cpu_bus.sv
test/cpu_bus_assertions.sv
test/cpu_bus_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= cpu_bus_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

# pass only if the testbench printed its pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
